//--- sources.f
verilog/loop_pkg.sv
verilog/csr_map_pkg.sv
verilog/err_demodulator.sv
verilog/feedback_step_gen.sv
verilog/phase_ramp_gen.sv
verilog/loop_csr.sv
verilog/closed_loop_top.sv
tb/tb_closed_loop_top.sv

//--- Makefile
# Verilator build and run of the closed phase loop testbench

VERILATOR ?= verilator
TOP       ?= tb_closed_loop_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# the run fails unless the pass line shows up in the simulator output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_closed_loop_top.sv
// ----------------------------------------------------------
// directed testbench of the closed phase loop, with a
// reference loop model and Wishbone register access
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_closed_loop_top
	import loop_pkg::*;
	import csr_map_pkg::*;
();

	localparam int ACK_TIMEOUT = 20;
	localparam int MOD_TIMEOUT = 200; // well above two of the longest half periods

	logic                clk = 1'b0;
	logic                rst_n = 1'b0;
	adc_sample_t         adc_data = '0;
	logic                adc_valid = 1'b0;
	logic                wb_cyc;
	logic                wb_stb;
	logic                wb_we;
	logic [WB_ADR_W-1:0] wb_adr;
	wb_data_t            wb_dat_w;
	wb_data_t            wb_dat_r;
	logic                wb_ack;
	phase_t              dac_code;
	logic                mod_sign;

	int          adc_mode = 0;      // 0 zero, 1 offset in the first half, 2 random
	adc_sample_t offset = '0;
	logic [15:0] lfsr = 16'd89;
	int          n_checks = 0;
	int          n_errors = 0;
	int          test_errors = 0;
	string       cur_test = "";
	loop_word_t  last_step = '0;
	phase_t      last_phase = '0;

	// reference model state, register copies follow the bus writes
	gain_t      ref_gain;
	loop_word_t ref_step_max;
	int         ref_hp_reg;
	int         ref_hp;
	int         ref_cnt;
	logic       ref_sign;
	gain_t      ref_shift;
	loop_word_t ref_sum;
	loop_word_t ref_integ;
	loop_word_t ref_lim;
	loop_word_t ref_clamp;
	loop_word_t ref_step;
	phase_t     ref_phase;

	always #5 clk = ~clk;

	closed_loop_top closed_loop_top_i (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_adc_data  (adc_data),
		.i_adc_valid (adc_valid),
		.i_wb_cyc    (wb_cyc),
		.i_wb_stb    (wb_stb),
		.i_wb_we     (wb_we),
		.i_wb_adr    (wb_adr),
		.i_wb_dat    (wb_dat_w),
		.o_wb_dat    (wb_dat_r),
		.o_wb_ack    (wb_ack),
		.o_dac_code  (dac_code),
		.o_mod_sign  (mod_sign)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// ---------------------------------------------------------
	// ADC stimulus, driven on the falling edge
	// ---------------------------------------------------------
	always @(negedge clk) begin : adc_drive
		logic [31:0] r;
		logic [31:0] v;
		case (adc_mode)
			1: begin
				adc_data  <= ref_sign ? '0 : offset; // model sign is the one for the next edge
				adc_valid <= 1'b1;
			end
			2: begin
				take_bits(14, r);
				take_bits(2, v);
				adc_data  <= r[13:0];
				adc_valid <= (v[1:0] != 2'b00);
			end
			default: begin
				adc_data  <= '0;
				adc_valid <= 1'b1;
			end
		endcase
	end

	// ---------------------------------------------------------
	// reference loop model
	// ---------------------------------------------------------
	always @(posedge clk or negedge rst_n) begin : loop_model
		loop_word_t x;
		if (!rst_n) begin
			ref_hp    = 16;
			ref_cnt   = 0;
			ref_sign  = 1'b0;
			ref_shift = 4'd5;
			ref_sum   = 0;
			ref_integ = 0;
			ref_step  = 0;
			ref_phase = '0;
		end else begin
			x = loop_word_t'(adc_data);
			if (adc_valid)
				ref_sum = ref_sign ? ref_sum - x : ref_sum + x;
			if (ref_cnt == 2 * ref_hp - 1) begin
				ref_cnt   = 0;
				ref_hp    = ref_hp_reg; // a new half period starts with a whole period
				ref_shift = ref_gain;
				if (ref_gain == 4'd15) begin
					ref_integ = 0;
					ref_step  = 0;
				end else begin
					ref_integ = ref_integ + ref_sum;
					ref_lim   = ref_step_max <<< ref_shift;
					if (ref_integ > ref_lim)
						ref_clamp = ref_lim;
					else if (ref_integ < -ref_lim)
						ref_clamp = -ref_lim;
					else
						ref_clamp = ref_integ;
					ref_step = ref_clamp >>> ref_shift;
				end
				ref_phase = ref_phase + ref_step[PHASE_W-1:0]; // wraps at 2 pi
				ref_sum   = 0;
			end else begin
				ref_cnt++;
			end
			ref_sign = (ref_cnt >= ref_hp);
		end
	end

	// ---------------------------------------------------------
	// checks and bookkeeping
	// ---------------------------------------------------------
	task automatic check_word(input string what, input loop_word_t exp, input loop_word_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_phase(input string what, input phase_t exp, input phase_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected 0x%04h, actual 0x%04h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = n_errors;
	endtask

	task automatic end_test();
		if (n_errors == test_errors)
			$display("test %s: ok", cur_test);
		else
			$display("test %s: %0d errors", cur_test, n_errors - test_errors);
	endtask

	// ---------------------------------------------------------
	// Wishbone classic master, called on a falling edge
	// ---------------------------------------------------------
	task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
	                          input wb_data_t dat, output wb_data_t rd);
		int n;
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		rd       = '0;
		for (n = 0; n < ACK_TIMEOUT; n++) begin
			@(negedge clk);
			if (wb_ack)
				break;
		end
		rd = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk);
		if (n == ACK_TIMEOUT) begin
			n_errors++;
			$display("%s: no ack from the bus within %0d cycles", cur_test, ACK_TIMEOUT);
		end else if (wb_ack) begin
			n_errors++;
			$display("%s: ack stayed high for more than one cycle", cur_test);
		end
	endtask

	task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input wb_data_t dat);
		wb_data_t rd;
		bus_access(1'b1, adr, dat, rd);
		case (adr)
			ADR_CTRL:        ref_gain     = dat[3:0];
			ADR_STEP_MAX:    ref_step_max = dat;
			ADR_HALF_PERIOD: ref_hp_reg   = int'(dat[HALF_PERIOD_W-1:0]);
			default:         ;
		endcase
	endtask

	task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output wb_data_t rd);
		bus_access(1'b0, adr, '0, rd);
	endtask

	// returns on the falling edge right after mod_sign rises
	task automatic wait_mod_edge();
		int   n;
		logic prev;
		prev = mod_sign;
		for (n = 0; n < MOD_TIMEOUT; n++) begin
			@(negedge clk);
			if (mod_sign && !prev)
				break;
			prev = mod_sign;
		end
		if (n == MOD_TIMEOUT) begin
			n_errors++;
			$display("%s: mod_sign did not rise within %0d cycles", cur_test, MOD_TIMEOUT);
		end else begin
			check_bit("mod_sign", ref_sign, mod_sign);
		end
	endtask

	// step and phase of the period that just ended, plus the biased DAC code
	task automatic check_period();
		wb_data_t rd;
		wb_read(ADR_STEP, rd);
		check_word("step", ref_step, rd);
		last_step = rd;
		wb_read(ADR_PHASE, rd);
		check_phase("phase", ref_phase, rd[PHASE_W-1:0]);
		last_phase = rd[PHASE_W-1:0];
		check_phase("dac code", ref_phase - BIAS_PHASE, dac_code);
	endtask

	task automatic run_periods(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			wait_mod_edge();
			check_period();
		end
	endtask

	// ---------------------------------------------------------
	// directed tests
	// ---------------------------------------------------------
	task automatic reset_values_test();
		wb_data_t rd;
		start_test("reset_values");
		check_bit("mod_sign", 1'b0, mod_sign);
		wb_read(ADR_CTRL, rd);
		check_word("ctrl", 5, rd);
		wb_read(ADR_STEP_MAX, rd);
		check_word("step_max", 5000, rd);
		wb_read(ADR_HALF_PERIOD, rd);
		check_word("half_period", 16, rd);
		wb_read(ADR_STATUS, rd);
		check_word("status", 1, rd);
		wb_read(ADR_STEP, rd);
		check_word("step", 0, rd);
		wb_read(ADR_PHASE, rd);
		check_word("phase", 0, rd);
		end_test();
	endtask

	task automatic register_access_test();
		wb_data_t rd;
		start_test("register_access");
		wait_mod_edge();
		wb_write(ADR_STEP_MAX, 32'd1234);
		wb_read(ADR_STEP_MAX, rd);
		check_word("step_max", 1234, rd);
		wb_write(ADR_CTRL, 32'd7);
		wb_read(ADR_CTRL, rd);
		check_word("ctrl", 7, rd);
		wait_mod_edge();
		wb_write(ADR_HALF_PERIOD, 32'd20);
		wb_read(ADR_HALF_PERIOD, rd);
		check_word("half_period", 20, rd);
		wb_write(ADR_STEP, 32'h0000_dead);
		wb_read(ADR_STEP, rd);
		check_word("step after write", 0, rd);
		wait_mod_edge();
		wb_write(ADR_PHASE, 32'h0000_1234);
		wb_read(ADR_PHASE, rd);
		check_word("phase after write", 0, rd);
		wb_write(4'd9, 32'hffff_ffff);
		wb_read(4'd9, rd);
		check_word("unmapped", 0, rd);
		wait_mod_edge();
		wb_write(ADR_CTRL, 32'd5);
		wb_write(ADR_STEP_MAX, 32'd5000);
		wb_write(ADR_HALF_PERIOD, 32'd16);
		end_test();
	endtask

	task automatic open_loop_test();
		wb_data_t rd;
		int       i;
		logic     prev;
		start_test("open_loop");
		wait_mod_edge();
		wb_write(ADR_CTRL, 32'd15);
		adc_mode = 2;
		wait_mod_edge(); // gain is taken at the period end in between
		wb_read(ADR_STATUS, rd);
		check_word("status", 0, rd);
		for (i = 0; i < 4; i++) begin
			wait_mod_edge();
			check_period();
			check_word("open step", 0, last_step);
			check_phase("open phase", '0, last_phase);
		end
		// the DAC code follows the sign of the cycle before
		prev = mod_sign;
		for (i = 0; i < 36; i++) begin
			@(negedge clk);
			check_phase("bias", prev ? phase_t'(16'h0 - BIAS_PHASE) : BIAS_PHASE, dac_code);
			check_bit("mod_sign", ref_sign, mod_sign);
			prev = mod_sign;
		end
		end_test();
	endtask

	task automatic integration_test();
		start_test("integration");
		adc_mode = 1;
		offset   = 14'sd100;
		wait_mod_edge();
		wait_mod_edge();
		wb_write(ADR_STEP_MAX, 32'h0100_0000);
		wb_write(ADR_CTRL, 32'd0);
		run_periods(10); // phase passes 2 pi on the way
		wait_mod_edge();
		check_period();
		wb_write(ADR_CTRL, 32'd3);
		offset = -14'sd300;
		run_periods(6);
		end_test();
	endtask

	task automatic saturation_test();
		start_test("saturation");
		wait_mod_edge();
		wb_write(ADR_STEP_MAX, 32'd50);
		wb_write(ADR_CTRL, 32'd2);
		offset = 14'sd400;
		run_periods(6);
		check_word("step at positive clamp", 50, last_step);
		offset = -14'sd400;
		run_periods(10);
		check_word("step at negative clamp", -50, last_step);
		end_test();
	endtask

	task automatic gain_period_test();
		int k;
		start_test("gain_period_change");
		adc_mode = 2;
		wait_mod_edge();
		wb_write(ADR_STEP_MAX, 32'd2000);
		wb_write(ADR_CTRL, 32'd1);
		for (k = 0; k < 8; k++) begin
			wait_mod_edge();
			check_period();
			// each change lands in the middle of a period
			case (k)
				1: wb_write(ADR_CTRL, 32'd4);
				2: wb_write(ADR_HALF_PERIOD, 32'd24);
				4: wb_write(ADR_CTRL, 32'd0);
				5: wb_write(ADR_HALF_PERIOD, 32'd14);
				6: wb_write(ADR_CTRL, 32'd2);
				default: ;
			endcase
		end
		end_test();
	endtask

	initial begin
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		ref_gain     = 4'd5;
		ref_step_max = 5000;
		ref_hp_reg   = 16;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		reset_values_test();
		register_access_test();
		open_loop_test();
		integration_test();
		saturation_test();
		gain_period_test();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/closed_loop_top.sv
// ----------------------------------------------------------
// closed phase loop: demodulator, loop filter, phase ramp and
// the Wishbone register block wired together
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module closed_loop_top
	import loop_pkg::*;
	import csr_map_pkg::*;
(
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  adc_sample_t         i_adc_data,
	input  logic                i_adc_valid,
	input  logic                i_wb_cyc,
	input  logic                i_wb_stb,
	input  logic                i_wb_we,
	input  logic [WB_ADR_W-1:0] i_wb_adr,
	input  wb_data_t            i_wb_dat,
	output wb_data_t            o_wb_dat,
	output logic                o_wb_ack,
	output phase_t              o_dac_code,
	output logic                o_mod_sign
);

	// control from the register block
	gain_t                    gain;
	loop_word_t               step_max;
	logic [HALF_PERIOD_W-1:0] half_period;

	// loop path
	loop_word_t err;
	logic       err_valid;
	loop_word_t step;
	logic       step_valid;
	logic       fb_on;
	phase_t     phase;

	err_demodulator err_demodulator_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_adc_data    (i_adc_data),
		.i_adc_valid   (i_adc_valid),
		.i_half_period (half_period),
		.o_mod_sign    (o_mod_sign),
		.o_err         (err),
		.o_err_valid   (err_valid)
	);

	feedback_step_gen feedback_step_gen_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_err        (err),
		.i_err_valid  (err_valid),
		.i_gain       (gain),
		.i_step_max   (step_max),
		.o_fb_on      (fb_on),
		.o_step       (step),
		.o_step_valid (step_valid)
	);

	phase_ramp_gen phase_ramp_gen_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_step       (step),
		.i_step_valid (step_valid),
		.i_mod_sign   (o_mod_sign),
		.o_phase      (phase),
		.o_dac_code   (o_dac_code)
	);

	loop_csr loop_csr_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_wb_cyc      (i_wb_cyc),
		.i_wb_stb      (i_wb_stb),
		.i_wb_we       (i_wb_we),
		.i_wb_adr      (i_wb_adr),
		.i_wb_dat      (i_wb_dat),
		.o_wb_dat      (o_wb_dat),
		.o_wb_ack      (o_wb_ack),
		.o_gain        (gain),
		.o_step_max    (step_max),
		.o_half_period (half_period),
		.i_fb_on       (fb_on),
		.i_step        (step),
		.i_step_valid  (step_valid),
		.i_phase       (phase)
	);

endmodule

`default_nettype wire

//--- verilog/loop_csr.sv
// ----------------------------------------------------------
// Wishbone classic slave with the loop control registers and
// read-back of loop status, last step and ramp phase
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module loop_csr
	import loop_pkg::*;
	import csr_map_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_wb_cyc,
	input  logic                     i_wb_stb,
	input  logic                     i_wb_we,
	input  logic [WB_ADR_W-1:0]      i_wb_adr,
	input  wb_data_t                 i_wb_dat,
	output wb_data_t                 o_wb_dat,
	output logic                     o_wb_ack,
	output gain_t                    o_gain,
	output loop_word_t               o_step_max,
	output logic [HALF_PERIOD_W-1:0] o_half_period,
	input  logic                     i_fb_on,
	input  loop_word_t               i_step,
	input  logic                     i_step_valid,
	input  phase_t                   i_phase
);

	logic       bus_req;
	loop_word_t step_q;
	wb_data_t   rd_data;

	// a new access is one with cyc and stb up while no ack is pending
	assign bus_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= bus_req; // one cycle, then low again
	end

	// ---------------------------------------------------------
	// control registers, written on the ack edge
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_gain        <= GAIN_RST;
			o_step_max    <= STEP_MAX_RST;
			o_half_period <= HALF_PERIOD_RST;
		end else if (bus_req && i_wb_we) begin
			case (i_wb_adr)
				ADR_CTRL:        o_gain        <= i_wb_dat[CTRL_GAIN_LSB +: CTRL_GAIN_W];
				ADR_STEP_MAX:    o_step_max    <= i_wb_dat;
				ADR_HALF_PERIOD: o_half_period <= i_wb_dat[HALF_PERIOD_W-1:0];
				default:         ; // status, step, phase and holes ignore writes
			endcase
		end
	end

	// step is sampled on its strobe so a read never sees a half updated value
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			step_q <= '0;
		else if (i_step_valid)
			step_q <= i_step;
	end

	// ---------------------------------------------------------
	// read mux
	// ---------------------------------------------------------
	always_comb begin
		rd_data = '0;
		case (i_wb_adr)
			ADR_CTRL:        rd_data[CTRL_GAIN_LSB +: CTRL_GAIN_W] = o_gain;
			ADR_STEP_MAX:    rd_data = o_step_max;
			ADR_HALF_PERIOD: rd_data[HALF_PERIOD_W-1:0] = o_half_period;
			ADR_STATUS:      rd_data[STATUS_FB_ON_BIT] = i_fb_on;
			ADR_STEP:        rd_data = step_q;
			ADR_PHASE:       rd_data[PHASE_W-1:0] = i_phase;
			default:         rd_data = '0;
		endcase
	end

	// read data goes out together with ack
	always_ff @(posedge i_clk) begin
		if (bus_req)
			o_wb_dat <= rd_data;
	end

endmodule

`default_nettype wire

//--- verilog/phase_ramp_gen.sv
// ----------------------------------------------------------
// serrodyne staircase: accumulates feedback steps modulo 2 pi
// and adds the square-wave bias to form the modulator DAC code
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module phase_ramp_gen
	import loop_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  loop_word_t i_step,
	input  logic       i_step_valid,
	input  logic       i_mod_sign,
	output phase_t     o_phase,
	output phase_t     o_dac_code
);

	phase_t phase_q;
	phase_t step_lo;
	phase_t phase_biased;

	// the phase code spans exactly 2 pi, so dropping the upper step bits is the wrap
	assign step_lo = i_step[PHASE_W-1:0];

	// ---------------------------------------------------------
	// staircase accumulator
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_q <= '0;
		end else if (i_step_valid) begin
			phase_q <= phase_q + step_lo; // natural modulo 2 pi
		end
	end

	// bias of +pi/2 in the first half period and -pi/2 in the second
	assign phase_biased = i_mod_sign ? phase_q - BIAS_PHASE : phase_q + BIAS_PHASE;

	// ---------------------------------------------------------
	// DAC output register
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_dac_code <= '0;
		else
			o_dac_code <= phase_biased; // updated every cycle
	end

	assign o_phase = phase_q;

endmodule

`default_nettype wire

//--- verilog/feedback_step_gen.sv
// ----------------------------------------------------------
// loop filter: integrates the demodulated error, clamps it and
// scales it by the gain shift into a feedback phase step
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module feedback_step_gen
	import loop_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  loop_word_t i_err,
	input  logic       i_err_valid,
	input  gain_t      i_gain,     // right shift, GAIN_OFF opens the loop
	input  loop_word_t i_step_max,
	output logic       o_fb_on,
	output loop_word_t o_step,
	output logic       o_step_valid
);

	gain_t      shift_q;
	loop_word_t integ_q;
	loop_word_t clamp_q;
	loop_word_t lim_pos;
	loop_word_t lim_neg;
	logic       trig_d1;
	logic       trig_d2;

	assign o_fb_on = (shift_q != GAIN_OFF);

	// the clamp works on the unscaled integrator so the bound is scaled up by the shift
	assign lim_pos = i_step_max <<< shift_q;
	assign lim_neg = -lim_pos;

	// ---------------------------------------------------------
	// gain latch and integrator, both on the error strobe
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shift_q <= GAIN_RST;
			integ_q <= '0;
		end else if (i_err_valid) begin
			shift_q <= i_gain; // held until the next period
			if (i_gain == GAIN_OFF)
				integ_q <= '0;
			else
				integ_q <= integ_q + i_err;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			trig_d1 <= 1'b0;
			trig_d2 <= 1'b0;
		end else begin
			trig_d1 <= i_err_valid;
			trig_d2 <= trig_d1;
		end
	end

	// ---------------------------------------------------------
	// clamp stage, one cycle behind the integrator
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			clamp_q <= '0;
		end else if (!o_fb_on) begin
			clamp_q <= '0;
		end else if (trig_d1) begin
			if (integ_q > lim_pos)
				clamp_q <= lim_pos;
			else if (integ_q < lim_neg)
				clamp_q <= lim_neg;
			else
				clamp_q <= integ_q;
		end
	end

	assign o_step       = clamp_q >>> shift_q; // arithmetic, keeps the sign
	assign o_step_valid = trig_d2;

endmodule

`default_nettype wire

//--- verilog/err_demodulator.sv
// ----------------------------------------------------------
// square-wave bias sequencer and synchronous demodulator,
// gives one signed error word per modulation period
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module err_demodulator
	import loop_pkg::*;
(
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  adc_sample_t              i_adc_data,
	input  logic                     i_adc_valid,
	input  logic [HALF_PERIOD_W-1:0] i_half_period,
	output logic                     o_mod_sign,
	output loop_word_t               o_err,
	output logic                     o_err_valid
);

	logic [HALF_PERIOD_W-1:0] hp_q;  // half period in use for this period
	logic [HALF_PERIOD_W-1:0] cnt_q; // position inside the current half
	logic                     half_end;
	logic                     period_end;
	loop_word_t               sample_ext;
	loop_word_t               acc_q;
	loop_word_t               acc_next;

	assign half_end   = (cnt_q == hp_q - 1'b1);
	assign period_end = half_end & o_mod_sign; // last cycle of the second half

	// samples of the first half are added and those of the second half subtracted
	assign sample_ext = {{(ACC_W-ADC_W){i_adc_data[ADC_W-1]}}, i_adc_data};
	assign acc_next   = !i_adc_valid ? acc_q :
	                    o_mod_sign   ? acc_q - sample_ext : acc_q + sample_ext;

	// ---------------------------------------------------------
	// period sequencing
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_q      <= '0;
			o_mod_sign <= 1'b0;
			hp_q       <= HALF_PERIOD_RST;
		end else if (half_end) begin
			cnt_q      <= '0;
			o_mod_sign <= ~o_mod_sign;
			// a new half period only starts on a whole period
			if (period_end)
				hp_q <= i_half_period;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// ---------------------------------------------------------
	// demodulation accumulator
	// ---------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			acc_q       <= '0;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= period_end;
			acc_q       <= period_end ? '0 : acc_next; // restart for the next period
		end
	end

	always_ff @(posedge i_clk) begin
		if (period_end)
			o_err <= acc_next; // includes the sample of the last cycle
	end

endmodule

`default_nettype wire

//--- verilog/csr_map_pkg.sv
// ----------------------------------------------------------
// Wishbone widths and register map of the loop control block
// ----------------------------------------------------------
`default_nettype none

package csr_map_pkg;

	localparam int WB_ADR_W = 4; // word address
	localparam int WB_DAT_W = 32;

	typedef logic [WB_DAT_W-1:0] wb_data_t;

	// ---------------------------------------------------------
	// word addresses
	// ---------------------------------------------------------
	localparam logic [WB_ADR_W-1:0] ADR_CTRL        = 4'd0;
	localparam logic [WB_ADR_W-1:0] ADR_STEP_MAX    = 4'd1;
	localparam logic [WB_ADR_W-1:0] ADR_HALF_PERIOD = 4'd2;
	localparam logic [WB_ADR_W-1:0] ADR_STATUS      = 4'd3;
	localparam logic [WB_ADR_W-1:0] ADR_STEP        = 4'd4; // read only
	localparam logic [WB_ADR_W-1:0] ADR_PHASE       = 4'd5; // read only

	// field positions
	localparam int CTRL_GAIN_LSB    = 0;
	localparam int CTRL_GAIN_W      = 4;
	localparam int STATUS_FB_ON_BIT = 0;

endpackage

`default_nettype wire

//--- verilog/loop_pkg.sv
// ----------------------------------------------------------
// loop datapath widths, payload types and reset constants,
// imported by every block of the closed phase loop
// ----------------------------------------------------------
`default_nettype none

package loop_pkg;

	localparam int ADC_W         = 14; // parallel ADC word
	localparam int ACC_W         = 32; // error, integrator and step
	localparam int PHASE_W       = 16; // DAC code, full scale is 2 pi
	localparam int GAIN_W        = 4;
	localparam int HALF_PERIOD_W = 12;

	typedef logic signed [ADC_W-1:0]   adc_sample_t;
	typedef logic signed [ACC_W-1:0]   loop_word_t;
	typedef logic        [PHASE_W-1:0] phase_t;
	typedef logic        [GAIN_W-1:0]  gain_t;

	localparam phase_t     BIAS_PHASE = 16'h4000; // pi/2
	localparam gain_t      GAIN_OFF   = 4'd15;    // shift code that opens the loop
	localparam gain_t      GAIN_RST   = 4'd5;
	localparam loop_word_t STEP_MAX_RST = 32'sd5000;

	// half period in clock cycles
	localparam logic [HALF_PERIOD_W-1:0] HALF_PERIOD_RST = 12'd16;

endpackage

`default_nettype wire
